// File: build.f
+incdir+common
common/fifo_pkg.sv
common/uart_pkg.sv
common/uart_fifo_if.sv
hw/sfifo.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_top.sv
tests/tb_clkgen.sv
tests/tb_uart_top.sv

// File: Makefile
# Verilator simulation of the UART testbench
VERILATOR ?= verilator
TOP       ?= tb_uart_top
RTL_TOP   ?= uart_top
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_uart_top.sv
/*
 * Testbench for uart_top. Inputs change and outputs are sampled on the falling edge.
 * i_rxd comes either from o_txd (loopback) or from a line driven here
 */

`timescale 1ns/1ps

`include "uart_defines.svh"

module tb_uart_top;
    import uart_pkg::*;
    import fifo_pkg::*;

    localparam int CLK_PERIOD_NS = 4;
    localparam int CPB           = `UART_CLKS_PER_BIT;
    localparam int DEPTH         = 1 << `UART_FIFO_LOG2_DEPTH;
    localparam int FRAME_CYCLES  = 10 * CPB;
    localparam int TOTAL_FRAMES  = 1 + 12 + 18 + 2;
    localparam int WATCHDOG_NS   = TOTAL_FRAMES * FRAME_CYCLES * CLK_PERIOD_NS * 2;

    logic        clk;
    logic        nrst;
    logic        tx_we;
    uart_byte_t  tx_wdata;
    fifo_count_t tx_count;
    logic        rx_re;
    uart_byte_t  rx_rdata;
    fifo_count_t rx_count;
    logic        txd;
    logic        rxd;
    logic        tx_busy;
    logic        frame_err;
    logic        loopback;
    logic        line_rxd;

    integer     seed;
    int         errors;
    int         errors_at_start;
    int         tests_run;
    int         tests_failed;
    int         ferr_pulses;
    uart_byte_t ref_q[$];

    tb_clkgen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(2)) clkgen (
        .o_clk  (clk),
        .o_nrst (nrst)
    );

    uart_top uut (
        .i_clk       (clk),
        .i_nrst      (nrst),
        .i_tx_we     (tx_we),
        .i_tx_wdata  (tx_wdata),
        .o_tx_count  (tx_count),
        .i_rx_re     (rx_re),
        .o_rx_rdata  (rx_rdata),
        .o_rx_count  (rx_count),
        .o_txd       (txd),
        .i_rxd       (rxd),
        .o_tx_busy   (tx_busy),
        .o_frame_err (frame_err)
    );

    assign rxd = loopback ? txd : line_rxd;

    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ferr_pulses <= 0;
        end else if (frame_err) begin
            ferr_pulses <= ferr_pulses + 1;
        end
    end

    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    a_idle_line: assert property (@(posedge clk) disable iff (!nrst) !tx_busy |-> txd)
        else report_mismatch("o_txd low while the transmitter is idle");
    a_rx_bound: assert property (@(posedge clk) disable iff (!nrst)
        rx_count <= fifo_count_t'(DEPTH))
        else report_mismatch($sformatf("o_rx_count %0d above depth", rx_count));
    a_tx_bound: assert property (@(posedge clk) disable iff (!nrst)
        tx_count <= fifo_count_t'(DEPTH))
        else report_mismatch($sformatf("o_tx_count %0d above depth", tx_count));
    a_ferr_single: assert property (@(posedge clk) disable iff (!nrst) frame_err |=> !frame_err)
        else report_mismatch("o_frame_err longer than one cycle");
    a_no_ferr_loop: assert property (@(posedge clk) disable iff (!nrst) loopback |-> !frame_err)
        else report_mismatch("o_frame_err on a loopback frame");

    task automatic begin_test();
        errors_at_start = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     errors - errors_at_start);
        end
    endtask

    // Holds off while the transmit FIFO is full, leaves the write strobe on
    task automatic push_tx(input uart_byte_t data);
        int waited;
        waited = 0;
        @(negedge clk);
        tx_we = 1'b0;
        while (tx_count == fifo_count_t'(DEPTH) && waited < 2 * FRAME_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (tx_count == fifo_count_t'(DEPTH)) begin
            report_failure("transmit FIFO stayed full");
        end
        tx_we    = 1'b1;
        tx_wdata = data;
    endtask

    task automatic stop_tx();
        @(negedge clk);
        tx_we = 1'b0;
    endtask

    task automatic wait_tx_drained();
        int waited;
        waited = 0;
        while ((tx_count != '0 || tx_busy) && waited < FRAME_CYCLES * (DEPTH + 4)) begin
            @(negedge clk);
            waited++;
        end
        if (tx_count != '0 || tx_busy) begin
            report_failure("transmitter did not drain its FIFO");
        end
    endtask

    task automatic wait_rx_count(input int n);
        int waited;
        waited = 0;
        while (rx_count != fifo_count_t'(n) && waited < 2 * FRAME_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (rx_count != fifo_count_t'(n)) begin
            report_failure($sformatf("receive count stuck at %0d, never reached %0d", rx_count, n));
        end
    endtask

    task automatic wait_frame_err(input int start);
        int waited;
        waited = 0;
        while (ferr_pulses == start && waited < FRAME_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (ferr_pulses == start) begin
            report_failure("no frame error pulse after a bad stop bit");
        end
    endtask

    // Head word is compared before each pop
    task automatic pop_and_check(input int n);
        uart_byte_t expected;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            expected = ref_q.pop_front();
            a_pop_data: assert (rx_rdata == expected)
                else report_mismatch($sformatf("pop %0d read %h, expected %h", i, rx_rdata, expected));
            rx_re = 1'b1;
        end
        @(negedge clk);
        rx_re = 1'b0;
    endtask

    task automatic check_tx_frame(input uart_byte_t data);
        logic [9:0] expected;
        int         waited;
        expected = {1'b1, data, 1'b0};
        waited   = 0;
        while (txd && waited < FRAME_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (txd) begin
            report_failure("no start bit appeared on o_txd");
        end else begin
            // Move from just after the start edge to mid-bit
            repeat (CPB / 2) @(negedge clk);
            for (int i = 0; i < 10; i++) begin
                a_frame_bit: assert (txd == expected[i])
                    else report_mismatch($sformatf("frame bit %0d is %b, expected %b",
                                                   i, txd, expected[i]));
                if (i < 9) begin
                    repeat (CPB) @(negedge clk);
                end
            end
        end
    endtask

    task automatic drive_line_frame(input uart_byte_t data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            line_rxd = frame[i];
            repeat (CPB) @(negedge clk);
        end
        line_rxd = 1'b1;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run exceeded %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        uart_byte_t byte_val;
        int         ferr_start;
        int         rx_start;
        seed         = 92;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        tx_we        = 1'b0;
        tx_wdata     = '0;
        rx_re        = 1'b0;
        loopback     = 1'b0;
        line_rxd     = 1'b1;
        @(posedge nrst);
        @(negedge clk);

        begin_test();
        a_rst_txd: assert (txd === 1'b1) else report_mismatch("o_txd not high after reset");
        a_rst_flags: assert (tx_busy === 1'b0 && frame_err === 1'b0)
            else report_mismatch("o_tx_busy or o_frame_err set after reset");
        a_rst_counts: assert (tx_count === '0 && rx_count === '0 && rx_rdata === '0)
            else report_mismatch("counts or receive data not zero after reset");
        end_test("reset state");

        begin_test();
        byte_val = uart_byte_t'($random(seed));
        push_tx(byte_val);
        stop_tx();
        check_tx_frame(byte_val);
        wait_tx_drained();
        end_test("frame format");

        begin_test();
        @(negedge clk);
        loopback = 1'b1;
        for (int i = 0; i < 12; i++) begin
            byte_val = uart_byte_t'($random(seed));
            ref_q.push_back(byte_val);
            push_tx(byte_val);
        end
        stop_tx();
        wait_tx_drained();
        wait_rx_count(12);
        pop_and_check(12);
        a_loop_empty: assert (rx_count == '0)
            else report_mismatch($sformatf("o_rx_count %0d after popping all", rx_count));
        end_test("loopback order");

        begin_test();
        for (int i = 0; i < DEPTH + 2; i++) begin
            byte_val = uart_byte_t'($random(seed));
            ref_q.push_back(byte_val);
            push_tx(byte_val);
        end
        stop_tx();
        wait_tx_drained();
        // Receiver settles on the last stop bit within one bit time
        repeat (CPB) @(negedge clk);
        a_sat_full: assert (rx_count == fifo_count_t'(DEPTH))
            else report_mismatch($sformatf("o_rx_count %0d, expected %0d", rx_count, DEPTH));
        pop_and_check(DEPTH);
        ref_q.delete();
        a_sat_drained: assert (rx_count == '0)
            else report_mismatch($sformatf("o_rx_count %0d after popping all", rx_count));
        rx_re = 1'b1;
        repeat (2) @(negedge clk);
        rx_re = 1'b0;
        a_sat_empty: assert (rx_count == '0)
            else report_mismatch($sformatf("o_rx_count %0d after extra pops", rx_count));
        end_test("receive FIFO saturation");

        begin_test();
        @(negedge clk);
        loopback   = 1'b0;
        ferr_start = ferr_pulses;
        rx_start   = int'(rx_count);
        drive_line_frame(8'h3c, 1'b0);
        wait_frame_err(ferr_start);
        repeat (2 * CPB) @(negedge clk);
        a_ferr_once: assert (ferr_pulses == ferr_start + 1)
            else report_mismatch($sformatf("%0d frame error pulses, expected 1",
                                           ferr_pulses - ferr_start));
        a_ferr_drop: assert (rx_count == fifo_count_t'(rx_start))
            else report_mismatch("bad frame changed o_rx_count");
        byte_val = uart_byte_t'($random(seed));
        ref_q.push_back(byte_val);
        drive_line_frame(byte_val, 1'b1);
        wait_rx_count(rx_start + 1);
        pop_and_check(1);
        a_ferr_clean: assert (ferr_pulses == ferr_start + 1)
            else report_mismatch("frame error pulse on a good frame");
        end_test("frame error");

        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tests/tb_clkgen.sv
/* Free-running clock and an active-low reset released on a falling edge */

`timescale 1ns/1ps

module tb_clkgen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic o_clk,
    output logic o_nrst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
    end

    initial begin
        o_nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_nrst = 1'b1;
    end

endmodule

// File: uart/uart_top.sv
/*
 * Serial port with 16-word transmit and receive FIFOs. Fixed baud divider,
 * 8N1 only. Counts come straight from the FIFOs with no extra register stage
 */

`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_top (
    input  logic                  i_clk,
    input  logic                  i_nrst,
    input  logic                  i_tx_we,
    input  uart_pkg::uart_byte_t  i_tx_wdata,
    output fifo_pkg::fifo_count_t o_tx_count,
    input  logic                  i_rx_re,
    output uart_pkg::uart_byte_t  o_rx_rdata,
    output fifo_pkg::fifo_count_t o_rx_count,
    output logic                  o_txd,
    input  logic                  i_rxd,
    output logic                  o_tx_busy,
    output logic                  o_frame_err
);

    uart_fifo_if tx_fifo_bus ();
    uart_fifo_if rx_fifo_bus ();

    // Host writes the transmit FIFO
    assign tx_fifo_bus.we    = i_tx_we;
    assign tx_fifo_bus.wdata = i_tx_wdata;
    assign o_tx_count        = tx_fifo_bus.count;

    // Host reads the receive FIFO
    assign rx_fifo_bus.re = i_rx_re;
    assign o_rx_rdata     = rx_fifo_bus.rdata;
    assign o_rx_count     = rx_fifo_bus.count;

    sfifo #(
        .dbits      (`UART_DATA_BITS),
        .log2_depth (`UART_FIFO_LOG2_DEPTH)
    ) tx_fifo (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .bus    (tx_fifo_bus.fifo)
    );

    sfifo #(
        .dbits      (`UART_DATA_BITS),
        .log2_depth (`UART_FIFO_LOG2_DEPTH)
    ) rx_fifo (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .bus    (rx_fifo_bus.fifo)
    );

    uart_tx u_tx (
        .i_clk     (i_clk),
        .i_nrst    (i_nrst),
        .fifo      (tx_fifo_bus.consumer),
        .o_txd     (o_txd),
        .o_tx_busy (o_tx_busy)
    );

    uart_rx u_rx (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_rxd       (i_rxd),
        .fifo        (rx_fifo_bus.producer),
        .o_frame_err (o_frame_err)
    );

endmodule

// File: uart/uart_rx.sv
/*
 * 8N1 receiver with two-flop input synchronizer and mid-bit sampling.
 * Good bytes are pushed without a fullness check, so a full FIFO drops them.
 * A low stop bit drops the byte and pulses o_frame_err
 */

`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_rx (
    input  logic i_clk,
    input  logic i_nrst,
    input  logic i_rxd,
    uart_fifo_if.producer fifo,
    output logic o_frame_err
);
    import uart_pkg::*;

    localparam int IDX_W = $clog2(`UART_DATA_BITS);
    localparam bit_timer_t BIT_LAST = bit_timer_t'(`UART_CLKS_PER_BIT - 1);
    localparam bit_timer_t HALF_BIT = bit_timer_t'(`UART_CLKS_PER_BIT / 2 - 1);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`UART_DATA_BITS - 1);

    logic [1:0]       rxd_sync;
    logic             rxd_s;
    rx_state_e        state;
    bit_timer_t       timer;
    logic [IDX_W-1:0] bit_idx;
    uart_byte_t       shreg;

    logic bit_end;
    logic sample;

    // Idle line is high, so the synchronizer resets to one
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rxd_sync <= 2'b11;
        end else begin
            rxd_sync <= {rxd_sync[0], i_rxd};
        end
    end

    assign rxd_s   = rxd_sync[1];
    assign bit_end = (timer == BIT_LAST);
    assign sample  = (state == RX_DATA) && bit_end;

    // Bits arrive LSB first, so new bits enter at the top
    always_ff @(posedge i_clk) begin
        if (sample) begin
            shreg <= {rxd_s, shreg[`UART_DATA_BITS-1:1]};
        end
    end

    assign fifo.wdata = shreg;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state       <= RX_IDLE;
            timer       <= '0;
            bit_idx     <= '0;
            fifo.we     <= 1'b0;
            o_frame_err <= 1'b0;
        end else begin
            fifo.we     <= 1'b0;
            o_frame_err <= 1'b0;
            case (state)
                RX_IDLE: begin
                    timer <= '0;
                    if (!rxd_s) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // Recheck the start bit at its middle
                    if (timer == HALF_BIT) begin
                        timer   <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s ? RX_IDLE : RX_DATA;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_end) begin
                        timer <= '0;
                        if (bit_idx == IDX_LAST) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_end) begin
                        timer <= '0;
                        state <= RX_IDLE;
                        if (rxd_s) begin
                            fifo.we <= 1'b1;
                        end else begin
                            o_frame_err <= 1'b1;
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // A frame ends in exactly one single-cycle outcome
    a_one_outcome: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (fifo.we || o_frame_err) |-> !(fifo.we && o_frame_err) ##1 !(fifo.we || o_frame_err)
    ) else $error("uart_rx push and frame error overlap or repeat");

endmodule

// File: uart/uart_tx.sv
/*
 * 8N1 serializer. Pops one byte whenever idle and the FIFO is nonempty.
 * No back-pressure toward the host; watch the FIFO count instead
 */

`timescale 1ns/1ps

`include "uart_defines.svh"

module uart_tx (
    input  logic i_clk,
    input  logic i_nrst,
    uart_fifo_if.consumer fifo,
    output logic o_txd,
    output logic o_tx_busy
);
    import uart_pkg::*;

    localparam int IDX_W = $clog2(`UART_DATA_BITS);
    localparam bit_timer_t BIT_LAST = bit_timer_t'(`UART_CLKS_PER_BIT - 1);
    localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`UART_DATA_BITS - 1);

    tx_state_e        state;
    bit_timer_t       timer;
    logic [IDX_W-1:0] bit_idx;
    uart_byte_t       shreg;

    logic pop;
    logic bit_end;
    logic shift;

    assign pop     = (state == TX_IDLE) && (fifo.count != '0);
    assign bit_end = (timer == BIT_LAST);
    assign shift   = (state == TX_DATA) && bit_end && (bit_idx != IDX_LAST);

    assign fifo.re   = pop;
    assign o_tx_busy = (state != TX_IDLE);

    // Data shift register, LSB goes out first
    always_ff @(posedge i_clk) begin
        if (pop) begin
            shreg <= fifo.rdata;
        end else if (shift) begin
            shreg <= shreg >> 1;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state   <= TX_IDLE;
            timer   <= '0;
            bit_idx <= '0;
            o_txd   <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    timer <= '0;
                    if (pop) begin
                        state <= TX_START;
                        o_txd <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        timer   <= '0;
                        bit_idx <= '0;
                        state   <= TX_DATA;
                        o_txd   <= shreg[0];
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        timer <= '0;
                        if (bit_idx == IDX_LAST) begin
                            state <= TX_STOP;
                            o_txd <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            // Next bit before the shift lands
                            o_txd   <= shreg[1];
                        end
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        timer <= '0;
                        state <= TX_IDLE;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // One pop per frame, and never from an empty FIFO
    a_re_pulse: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        fifo.re |-> (fifo.count != '0) ##1 !fifo.re
    ) else $error("uart_tx pop from empty FIFO or longer than one cycle");

    a_idle_high: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (state == TX_IDLE) |-> o_txd
    ) else $error("uart_tx line low while idle");

endmodule

// File: hw/sfifo.sv
/*
 * Synchronous FIFO with word count. A write when full is dropped unless a read
 * happens in the same cycle, and a read when empty is ignored. dbits and log2_depth
 * must match the widths carried by uart_fifo_if
 */

`timescale 1ns/1ps

module sfifo #(
    parameter int dbits = 8,
    parameter int log2_depth = 4
) (
    input logic i_clk,
    input logic i_nrst,
    uart_fifo_if.fifo bus
);
    import fifo_pkg::*;

    localparam int DEPTH = 1 << log2_depth;

    logic [dbits-1:0] mem [DEPTH];

    fifo_ptr_t   wr_ptr;
    fifo_ptr_t   rd_ptr;
    fifo_count_t count;

    logic full;
    logic empty;
    logic wr_ok;
    logic rd_ok;

    // Full is the top count bit, only set at exactly DEPTH words
    assign full  = count[log2_depth];
    assign empty = (count == '0);

    // A full FIFO still accepts a write when the head leaves in the same cycle
    assign wr_ok = bus.we && (!full || bus.re);
    assign rd_ok = bus.re && !empty;

    always_ff @(posedge i_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= bus.wdata;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head word straight from the array, zero while empty
    assign bus.rdata = empty ? '0 : mem[rd_ptr];
    assign bus.count = count;

    a_count_bound: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        count <= fifo_count_t'(DEPTH)
    ) else $error("sfifo count above depth");

    // Write and read that both land must leave the fill level alone
    a_count_hold: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (bus.we && bus.re && !empty) |=> $stable(count)
    ) else $error("sfifo count moved on simultaneous write and read");

endmodule

// File: common/uart_fifo_if.sv
/*
 * Write and read sides of one byte FIFO.
 * rdata is valid whenever count is nonzero
 */

`timescale 1ns/1ps

interface uart_fifo_if;
    import uart_pkg::*;
    import fifo_pkg::*;

    logic        we;
    uart_byte_t  wdata;
    logic        re;
    uart_byte_t  rdata;
    fifo_count_t count;

    modport fifo (
        input  we,
        input  wdata,
        input  re,
        output rdata,
        output count
    );

    modport producer (
        output we,
        output wdata
    );

    modport consumer (
        output re,
        input  rdata,
        input  count
    );

endinterface

// File: common/uart_pkg.sv
/*
 * Serial-side types. State encodings are internal and may change
 */

`include "uart_defines.svh"

package uart_pkg;

    // One data byte on the line
    typedef logic [`UART_DATA_BITS-1:0] uart_byte_t;

    // Counts cycles inside one serial bit
    typedef logic [$clog2(`UART_CLKS_PER_BIT):0] bit_timer_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

endpackage

// File: common/fifo_pkg.sv
/*
 * FIFO index and word count types, sized from UART_FIFO_LOG2_DEPTH
 */

`include "uart_defines.svh"

package fifo_pkg;

    // Zero up to full depth, so one bit wider than an index
    typedef logic [`UART_FIFO_LOG2_DEPTH:0] fifo_count_t;

    // Read or write position in the register array
    typedef logic [`UART_FIFO_LOG2_DEPTH-1:0] fifo_ptr_t;

endpackage

// File: common/uart_defines.svh
/*
 * Compile-time UART and FIFO parameters. The baud rate follows from the
 * clock frequency divided by UART_CLKS_PER_BIT. Keep the FIFO depth a power of two
 */

`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Bits per serial byte, no parity
`define UART_DATA_BITS 8

// Both FIFOs hold 2**4 = 16 words
`define UART_FIFO_LOG2_DEPTH 4

// Clock cycles per serial bit
// Keep it even and at least 4 so the mid-bit sample point exists
`define UART_CLKS_PER_BIT 8

`endif
